// File: rtl/rc_update_pkg.sv
// shared codes for the status-update engine; only memory writes with data are described here
`default_nettype none

package rc_update_pkg;

	// --------------------------------------------------
	// writer phases
	// --------------------------------------------------
	// driven by the sequencer, read by writer and arbiter
	typedef enum logic [1:0] {
		st_idle     = 2'd0,
		st_start_tx = 2'd1,
		st_mwr_req  = 2'd2,
		st_mwr_dv   = 2'd3
	} wr_state_t;

	// payload packing select
	localparam int unsigned rc_upd_cmd_mode = 0;
	localparam int unsigned rc_upd_irq_mode = 1;

	// ring pointer widths
	localparam int unsigned rx_write_addr_width = 12;
	localparam int unsigned tx_read_addr_width  = 12;

	// --------------------------------------------------
	// tlp header fields
	// --------------------------------------------------
	// fmt for a write with data
	localparam logic [1:0] tlp_fmt_3dw_w = 2'b10;
	localparam logic [1:0] tlp_fmt_4dw_w = 2'b11;

	// memory request type
	localparam logic [4:0] tlp_type_write = 5'b00000;

	// traffic class, digest, poison, attributes all default
	localparam logic [2:0] tlp_tc_default   = 3'b000;
	localparam logic       tlp_td_default   = 1'b0;
	localparam logic       tlp_ep_default   = 1'b0;
	localparam logic [1:0] tlp_attr_default = 2'b00;

	// length field in dwords, one 128-bit beat
	localparam logic [9:0] data_dwords = 10'd4;

	// writers sharing the transmit port
	localparam int unsigned num_writers = 2;

endpackage

`default_nettype wire

// File: rtl/rc_update_sequencer.sv
// one packet in flight per writer; extra triggers during a packet collapse into one pending request
`timescale 1ns/1ps
`default_nettype none

module rc_update_sequencer import rc_update_pkg::*; (
	input  wire        clk_in,
	input  wire        rst_in,
	input  wire logic  trigger,
	input  wire logic  tx_sel,
	input  wire logic  tx_ack,
	input  wire logic  tx_dv,
	input  wire logic  tx_ws,
	output wr_state_t  cstate,
	output wr_state_t  nstate
);

	// trigger seen while busy
	logic pending;
	// beat taken before the ack came back
	logic beat_seen;
	// beat handed over this cycle
	logic beat_accept;

	assign beat_accept = tx_dv & ~tx_ws;

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb begin
		nstate = cstate;
		case (cstate)
			st_idle: begin
				// fresh strobe or one held from the last packet
				if (trigger || pending)
					nstate = st_start_tx;
			end
			st_start_tx: begin
				// wait for the port grant
				if (tx_sel)
					nstate = st_mwr_req;
			end
			st_mwr_req: begin
				if (tx_ack)
					nstate = st_mwr_dv;
			end
			st_mwr_dv: begin
				// single beat, done once it is taken
				if (beat_accept || beat_seen)
					nstate = st_idle;
			end
			default: nstate = st_idle;
		endcase
	end

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			cstate <= st_idle;
		else
			cstate <= nstate;
	end

	// pending flag, merged strobes
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			pending <= 1'b0;
		else if ((cstate == st_idle) && (nstate == st_start_tx))
			pending <= 1'b0;
		else if (trigger)
			pending <= 1'b1;
	end

	// the core may take the data ahead of tx_ack
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			beat_seen <= 1'b0;
		else if (nstate == st_idle)
			beat_seen <= 1'b0;
		else if ((cstate == st_mwr_req) && beat_accept)
			beat_seen <= 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/rc_update_writer.sv
// one 128-bit beat per packet with tag zero and no poisoning; inputs must hold until the beat is taken
`timescale 1ns/1ps
`default_nettype none

module rc_update_writer import rc_update_pkg::*; #(
	parameter int unsigned MODE = rc_upd_cmd_mode
) (
	// control
	input  wire                                  clk_in,
	input  wire                                  rst_in,
	input  wire                                  init,
	input  wire wr_state_t                       cstate,
	input  wire wr_state_t                       nstate,

	// transmit
	output logic                                 tx_req,
	input  wire logic                            tx_ack,
	output logic [127:0]                         tx_desc,
	input  wire logic                            tx_ws,
	output logic                                 tx_dv,
	output logic                                 tx_dfr,
	output logic [127:0]                         tx_data,

	// arbitration
	input  wire logic                            tx_sel,
	output logic                                 tx_busy,
	output logic                                 tx_ready,
	input  wire logic                            tx_ready_others,

	// address and command payload
	input  wire logic [63:0]                     base_rc,
	input  wire logic [63:0]                     cmd_response,
	input  wire logic [63:0]                     cmd_error_code,

	// interrupt payload
	input  wire logic                            sfp1_on,
	input  wire logic                            sfp2_on,
	input  wire logic [23:0]                     byte_ready,
	input  wire logic [31:0]                     byte_sent,
	input  wire logic [rx_write_addr_width-1:0]  rx_ring_wptr,
	input  wire logic [tx_read_addr_width-1:0]   tx_ring_rptr
);

	logic         upd_cycle;
	logic [127:0] payload;
	logic [127:0] data_reg;
	logic [63:0]  addr_reg;
	logic         addr_32b;
	logic         in_tx_phase;
	logic [1:0]   beat_cnt;
	logic [3:0]   lbe;

	// --------------------------------------------------
	// arbitration handshake
	// --------------------------------------------------
	// ready only while waiting and nobody else owns the port
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			tx_ready <= 1'b0;
		else
			tx_ready <= (cstate == st_start_tx) && !tx_ready_others && !tx_sel;
	end

	// busy one cycle early off nstate
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			tx_busy <= 1'b0;
		else
			tx_busy <= (nstate == st_mwr_req) || (nstate == st_mwr_dv);
	end

	// held until the core acks the descriptor
	assign tx_req = (cstate == st_mwr_req) && !tx_ack;

	// high from start_tx through the data phase
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			upd_cycle <= 1'b0;
		else if (init)
			upd_cycle <= 1'b0;
		else
			upd_cycle <= (cstate != st_idle);
	end

	// --------------------------------------------------
	// payload packing
	// --------------------------------------------------
	generate
		if (MODE == rc_upd_cmd_mode) begin : g_cmd
			// response high, error code low
			assign payload = {cmd_response, cmd_error_code};
		end else begin : g_irq
			// pointers zero-extended, bits 7:4 reserved
			assign payload = {{(32-tx_read_addr_width){1'b0}}, tx_ring_rptr,
				{(32-rx_write_addr_width){1'b0}}, rx_ring_wptr,
				byte_sent, byte_ready, 4'b0000,
				sfp1_on, sfp2_on, |byte_ready, 1'b1};
		end
	endgenerate

	always_ff @(posedge clk_in) begin
		data_reg <= upd_cycle ? payload : 128'h0;
	end

	assign tx_data = data_reg;

	// --------------------------------------------------
	// address, 3dw when the upper dword is zero
	// --------------------------------------------------
	always_ff @(posedge clk_in) begin
		if (init) begin
			addr_reg <= 64'h0;
			addr_32b <= 1'b0;
		end else if (base_rc[63:32] == 32'h0) begin
			// 3dw header carries the address in the upper half
			addr_reg <= {base_rc[31:0], 32'h0};
			addr_32b <= 1'b1;
		end else begin
			addr_reg <= base_rc;
			addr_32b <= 1'b0;
		end
	end

	// last byte enable only during the update
	assign lbe = upd_cycle ? 4'hf : 4'h0;

	// descriptor fields, reserved bits zero
	assign tx_desc[127]     = 1'b0;
	assign tx_desc[126:125] = (upd_cycle && addr_32b) ? tlp_fmt_3dw_w : tlp_fmt_4dw_w;
	assign tx_desc[124:120] = tlp_type_write;
	assign tx_desc[119]     = 1'b0;
	assign tx_desc[118:116] = tlp_tc_default;
	assign tx_desc[115:112] = 4'h0;
	assign tx_desc[111]     = tlp_td_default;
	assign tx_desc[110]     = tlp_ep_default;
	assign tx_desc[109:108] = tlp_attr_default;
	assign tx_desc[107:106] = 2'b00;
	assign tx_desc[105:96]  = data_dwords;
	// requester id filled in by the core
	assign tx_desc[95:80]   = 16'h0;
	// tag
	assign tx_desc[79:72]   = 8'h00;
	assign tx_desc[71:64]   = {lbe, 4'hf};
	assign tx_desc[63:0]    = addr_reg;

	// --------------------------------------------------
	// dfr / dv generation
	// --------------------------------------------------
	assign in_tx_phase = (cstate == st_mwr_req) || (cstate == st_mwr_dv);
	assign tx_dfr = in_tx_phase && (beat_cnt < 2'(data_dwords >> 2));

	// counts beats moved into the dv stage, frozen by ws
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			beat_cnt <= 2'd0;
		else if (!in_tx_phase)
			beat_cnt <= 2'd0;
		else if (tx_dfr && !tx_ws)
			beat_cnt <= beat_cnt + 2'd1;
	end

	// dv trails dfr, moves only while ws low
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			tx_dv <= 1'b0;
		else if (init)
			tx_dv <= 1'b0;
		else if (!tx_ws)
			tx_dv <= tx_dfr;
	end

endmodule

`default_nettype wire

// File: rtl/tx_port_arbiter.sv
// grant is kept from the first ready until the holder's busy falls; lowest index wins ties
`timescale 1ns/1ps
`default_nettype none

module tx_port_arbiter import rc_update_pkg::*; (
	input  wire                                     clk_in,
	input  wire                                     rst_in,

	// per-writer arbitration
	input  wire logic [num_writers-1:0]             tx_ready,
	input  wire logic [num_writers-1:0]             tx_busy,
	output logic      [num_writers-1:0]             tx_sel,
	output logic      [num_writers-1:0]             tx_ready_others,

	// per-writer transmit side
	input  wire logic [num_writers-1:0]             wr_tx_req,
	input  wire logic [num_writers-1:0][127:0]      wr_tx_desc,
	input  wire logic [num_writers-1:0]             wr_tx_dfr,
	input  wire logic [num_writers-1:0]             wr_tx_dv,
	input  wire logic [num_writers-1:0][127:0]      wr_tx_data,
	output logic      [num_writers-1:0]             wr_tx_ack,
	output logic      [num_writers-1:0]             wr_tx_ws,

	// shared port
	output logic                                    tx_req,
	input  wire logic                               tx_ack,
	output logic [127:0]                            tx_desc,
	input  wire logic                               tx_ws,
	output logic                                    tx_dv,
	output logic                                    tx_dfr,
	output logic [127:0]                            tx_data
);

	logic [num_writers-1:0] grant;
	logic [num_writers-1:0] grant_nxt;
	logic [num_writers-1:0] busy_q;

	// --------------------------------------------------
	// grant update
	// --------------------------------------------------
	always_comb begin
		grant_nxt = grant;
		if (grant == '0) begin
			// descending so the lowest ready index lands last
			for (int i = num_writers - 1; i >= 0; i--) begin
				if (tx_ready[i])
					grant_nxt = num_writers'(1) << i;
			end
		end else if (((busy_q & grant) != '0) && ((tx_busy & grant) == '0)) begin
			// holder finished its packet
			grant_nxt = '0;
		end
	end

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			grant  <= '0;
			busy_q <= '0;
		end else begin
			grant  <= grant_nxt;
			busy_q <= tx_busy;
		end
	end

	assign tx_sel = grant;

	// --------------------------------------------------
	// steering and port mux
	// --------------------------------------------------
	always_comb begin
		tx_req  = 1'b0;
		tx_desc = 128'h0;
		tx_dfr  = 1'b0;
		tx_dv   = 1'b0;
		tx_data = 128'h0;
		for (int i = 0; i < num_writers; i++) begin
			// someone other than writer i owns the port
			tx_ready_others[i] = |(grant & ~(num_writers'(1) << i));
			wr_tx_ack[i] = tx_ack & grant[i];
			wr_tx_ws[i]  = tx_ws & grant[i];
			// grant is one-hot, or-ing is enough
			tx_req  = tx_req  | (grant[i] & wr_tx_req[i]);
			tx_desc = tx_desc | ({128{grant[i]}} & wr_tx_desc[i]);
			tx_dfr  = tx_dfr  | (grant[i] & wr_tx_dfr[i]);
			tx_dv   = tx_dv   | (grant[i] & wr_tx_dv[i]);
			tx_data = tx_data | ({128{grant[i]}} & wr_tx_data[i]);
		end
	end

endmodule

`default_nettype wire

// File: rtl/rc_update_top.sv
// writer 0 reports commands, writer 1 reports interrupts; tx_err is not driven and stays low in the core
`timescale 1ns/1ps
`default_nettype none

module rc_update_top import rc_update_pkg::*; (
	input  wire                                  clk_in,
	input  wire                                  rst_in,
	input  wire                                  init,

	// command report
	input  wire logic                            cmd_done,
	input  wire logic [63:0]                     cmd_base_rc,
	input  wire logic [63:0]                     cmd_response,
	input  wire logic [63:0]                     cmd_error_code,

	// interrupt report
	input  wire logic                            irq_strobe,
	input  wire logic [63:0]                     irq_base_rc,
	input  wire logic                            sfp1_on,
	input  wire logic                            sfp2_on,
	input  wire logic [23:0]                     byte_ready,
	input  wire logic [31:0]                     byte_sent,
	input  wire logic [rx_write_addr_width-1:0]  rx_ring_wptr,
	input  wire logic [tx_read_addr_width-1:0]   tx_ring_rptr,

	// pcie core transmit
	output logic                                 tx_req,
	input  wire logic                            tx_ack,
	output logic [127:0]                         tx_desc,
	input  wire logic                            tx_ws,
	output logic                                 tx_dv,
	output logic                                 tx_dfr,
	output logic [127:0]                         tx_data
);

	wr_state_t                         cmd_cstate;
	wr_state_t                         cmd_nstate;
	wr_state_t                         irq_cstate;
	wr_state_t                         irq_nstate;

	// index 0 command, index 1 interrupt
	logic [num_writers-1:0]            wr_ready;
	logic [num_writers-1:0]            wr_busy;
	logic [num_writers-1:0]            wr_sel;
	logic [num_writers-1:0]            wr_ready_others;
	logic [num_writers-1:0]            wr_tx_req;
	logic [num_writers-1:0][127:0]     wr_tx_desc;
	logic [num_writers-1:0]            wr_tx_dfr;
	logic [num_writers-1:0]            wr_tx_dv;
	logic [num_writers-1:0][127:0]     wr_tx_data;
	logic [num_writers-1:0]            wr_tx_ack;
	logic [num_writers-1:0]            wr_tx_ws;

	// --------------------------------------------------
	// command path
	// --------------------------------------------------
	rc_update_sequencer cmd_seq_inst (
		.clk_in (clk_in), .rst_in (rst_in), .trigger (cmd_done),
		.tx_sel (wr_sel[0]), .tx_ack (wr_tx_ack[0]), .tx_dv (wr_tx_dv[0]),
		.tx_ws (wr_tx_ws[0]), .cstate (cmd_cstate), .nstate (cmd_nstate)
	);

	// interrupt status unused here
	rc_update_writer #(.MODE(rc_upd_cmd_mode)) cmd_writer_inst (
		.clk_in (clk_in), .rst_in (rst_in), .init (init),
		.cstate (cmd_cstate), .nstate (cmd_nstate),
		.tx_req (wr_tx_req[0]), .tx_ack (wr_tx_ack[0]), .tx_desc (wr_tx_desc[0]),
		.tx_ws (wr_tx_ws[0]), .tx_dv (wr_tx_dv[0]), .tx_dfr (wr_tx_dfr[0]),
		.tx_data (wr_tx_data[0]), .tx_sel (wr_sel[0]), .tx_busy (wr_busy[0]),
		.tx_ready (wr_ready[0]), .tx_ready_others (wr_ready_others[0]),
		.base_rc (cmd_base_rc), .cmd_response (cmd_response),
		.cmd_error_code (cmd_error_code), .sfp1_on (1'b0), .sfp2_on (1'b0),
		.byte_ready (24'h0), .byte_sent (32'h0),
		.rx_ring_wptr ({rx_write_addr_width{1'b0}}),
		.tx_ring_rptr ({tx_read_addr_width{1'b0}})
	);

	// --------------------------------------------------
	// interrupt path
	// --------------------------------------------------
	rc_update_sequencer irq_seq_inst (
		.clk_in (clk_in), .rst_in (rst_in), .trigger (irq_strobe),
		.tx_sel (wr_sel[1]), .tx_ack (wr_tx_ack[1]), .tx_dv (wr_tx_dv[1]),
		.tx_ws (wr_tx_ws[1]), .cstate (irq_cstate), .nstate (irq_nstate)
	);

	rc_update_writer #(.MODE(rc_upd_irq_mode)) irq_writer_inst (
		.clk_in (clk_in), .rst_in (rst_in), .init (init),
		.cstate (irq_cstate), .nstate (irq_nstate),
		.tx_req (wr_tx_req[1]), .tx_ack (wr_tx_ack[1]), .tx_desc (wr_tx_desc[1]),
		.tx_ws (wr_tx_ws[1]), .tx_dv (wr_tx_dv[1]), .tx_dfr (wr_tx_dfr[1]),
		.tx_data (wr_tx_data[1]), .tx_sel (wr_sel[1]), .tx_busy (wr_busy[1]),
		.tx_ready (wr_ready[1]), .tx_ready_others (wr_ready_others[1]),
		.base_rc (irq_base_rc), .cmd_response (64'h0), .cmd_error_code (64'h0),
		.sfp1_on (sfp1_on), .sfp2_on (sfp2_on), .byte_ready (byte_ready),
		.byte_sent (byte_sent), .rx_ring_wptr (rx_ring_wptr),
		.tx_ring_rptr (tx_ring_rptr)
	);

	// shared port
	tx_port_arbiter tx_port_arbiter_inst (
		.clk_in (clk_in), .rst_in (rst_in),
		.tx_ready (wr_ready), .tx_busy (wr_busy), .tx_sel (wr_sel),
		.tx_ready_others (wr_ready_others),
		.wr_tx_req (wr_tx_req), .wr_tx_desc (wr_tx_desc), .wr_tx_dfr (wr_tx_dfr),
		.wr_tx_dv (wr_tx_dv), .wr_tx_data (wr_tx_data),
		.wr_tx_ack (wr_tx_ack), .wr_tx_ws (wr_tx_ws),
		.tx_req (tx_req), .tx_ack (tx_ack), .tx_desc (tx_desc), .tx_ws (tx_ws),
		.tx_dv (tx_dv), .tx_dfr (tx_dfr), .tx_data (tx_data)
	);

endmodule

`default_nettype wire

// File: test/tx_sink_model.sv
// core transmit model for single-beat writes only; ack comes 1 to 4 cycles after tx_req, ws is random
`timescale 1ns/1ps
`default_nettype none

module tx_sink_model #(
	parameter logic [31:0] SEED = 32'd76034
) (
	input  wire                clk_in,
	input  wire                rst_in,
	input  wire logic          tx_req,
	input  wire logic [127:0]  tx_desc,
	input  wire logic          tx_dv,
	input  wire logic [127:0]  tx_data,
	output logic               tx_ack,
	output logic               tx_ws,
	output int unsigned        capture_count
);

	logic [31:0]  rng_state;
	logic [2:0]   ack_delay;
	logic [2:0]   req_age;
	logic [127:0] desc_hold;
	logic [127:0] desc_q[$];
	logic [127:0] data_q[$];

	// plain 32-bit lcg, upper bits used
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// --------------------------------------------------
	// ack and wait-state drive, falling edge
	// --------------------------------------------------
	always @(negedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			rng_state <= SEED;
			tx_ack    <= 1'b0;
			tx_ws     <= 1'b0;
			ack_delay <= 3'd1;
			req_age   <= 3'd0;
		end else begin
			rng_state <= lcg_next(rng_state);
			// stall about three cycles in eight
			tx_ws <= (rng_state[31:29] < 3'd3);
			// ack is a one-cycle pulse
			if (tx_ack) begin
				tx_ack <= 1'b0;
			end else if (tx_req) begin
				if (req_age == ack_delay) begin
					tx_ack    <= 1'b1;
					req_age   <= 3'd0;
					ack_delay <= 3'd1 + {1'b0, rng_state[17:16]};
				end else begin
					req_age <= req_age + 3'd1;
				end
			end
		end
	end

	// --------------------------------------------------
	// capture on each accepted beat
	// --------------------------------------------------
	always @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			capture_count <= 0;
			desc_q.delete();
			data_q.delete();
		end else begin
			if (tx_req)
				desc_hold <= tx_desc;
			// beat may be taken while tx_req is still up
			if (tx_dv && !tx_ws) begin
				desc_q.push_back(tx_req ? tx_desc : desc_hold);
				data_q.push_back(tx_data);
				capture_count <= capture_count + 1;
			end
		end
	end

	// oldest capture first
	task pop_capture(output logic [127:0] desc, output logic [127:0] data);
		desc = desc_q.pop_front();
		data = data_q.pop_front();
	endtask

endmodule

`default_nettype wire

// File: test/rc_update_tb.sv
// packet order between the two writers is not checked; payload inputs hold until each packet completes
`timescale 1ns/1ps
`default_nettype none

module rc_update_tb import rc_update_pkg::*; ();

	localparam int clk_period      = 40;
	localparam int reset_cycles    = 10;
	localparam int num_tests       = 6;
	localparam int cycles_per_test = 2000;
	localparam int random_packets  = 20;

	logic clk_in = 1'b0;
	logic rst_in;
	logic init;
	logic cmd_done;
	logic [63:0] cmd_base_rc;
	logic [63:0] cmd_response;
	logic [63:0] cmd_error_code;
	logic irq_strobe;
	logic [63:0] irq_base_rc;
	logic sfp1_on;
	logic sfp2_on;
	logic [23:0] byte_ready;
	logic [31:0] byte_sent;
	logic [rx_write_addr_width-1:0] rx_ring_wptr;
	logic [tx_read_addr_width-1:0] tx_ring_rptr;
	logic tx_req;
	logic tx_ack;
	logic [127:0] tx_desc;
	logic tx_ws;
	logic tx_dv;
	logic tx_dfr;
	logic [127:0] tx_data;

	int unsigned capture_count;
	int unsigned checked_count = 0;
	int unsigned expected_count = 0;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	logic [31:0] rng_state;
	logic [127:0] exp_desc_q[$];
	logic [127:0] exp_data_q[$];
	// framing monitor state
	logic req_q = 1'b0;
	logic ws_q = 1'b0;
	logic dv_q = 1'b0;
	logic pkt_open = 1'b0;

	always #(clk_period / 2) clk_in = ~clk_in;

	rc_update_top rc_update_top_inst (
		.clk_in (clk_in), .rst_in (rst_in), .init (init),
		.cmd_done (cmd_done), .cmd_base_rc (cmd_base_rc), .cmd_response (cmd_response),
		.cmd_error_code (cmd_error_code), .irq_strobe (irq_strobe), .irq_base_rc (irq_base_rc),
		.sfp1_on (sfp1_on), .sfp2_on (sfp2_on), .byte_ready (byte_ready),
		.byte_sent (byte_sent), .rx_ring_wptr (rx_ring_wptr), .tx_ring_rptr (tx_ring_rptr),
		.tx_req (tx_req), .tx_ack (tx_ack), .tx_desc (tx_desc), .tx_ws (tx_ws),
		.tx_dv (tx_dv), .tx_dfr (tx_dfr), .tx_data (tx_data)
	);

	tx_sink_model #(.SEED(32'd76034)) tx_sink_model_inst (
		.clk_in (clk_in), .rst_in (rst_in), .tx_req (tx_req), .tx_desc (tx_desc),
		.tx_dv (tx_dv), .tx_data (tx_data), .tx_ack (tx_ack), .tx_ws (tx_ws),
		.capture_count (capture_count)
	);

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	// returns {descriptor, data} for one status record
	function automatic logic [255:0] expected_packet(input int unsigned mode,
		input logic [63:0] base, input logic [63:0] resp, input logic [63:0] err_code);
		logic [127:0] desc;
		logic [127:0] data;
		logic is_3dw;
		is_3dw = (base[63:32] == 32'h0);
		desc = '0;
		desc[126:125] = is_3dw ? tlp_fmt_3dw_w : tlp_fmt_4dw_w;
		desc[124:120] = tlp_type_write;
		desc[105:96] = data_dwords;
		// last and first byte enables, tag stays zero
		desc[71:64] = 8'hff;
		desc[63:0] = is_3dw ? {base[31:0], 32'h0} : base;
		if (mode == rc_upd_cmd_mode) begin
			data = {resp, err_code};
		end else begin
			data = '0;
			data[127:96] = 32'(tx_ring_rptr);
			data[95:64] = 32'(rx_ring_wptr);
			data[63:32] = byte_sent;
			data[31:8] = byte_ready;
			data[3] = sfp1_on;
			data[2] = sfp2_on;
			data[1] = (byte_ready != 24'h0);
			data[0] = 1'b1;
		end
		return {desc, data};
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// two lcg steps, top halves joined
	task draw_random(output logic [31:0] value);
		rng_state = lcg_next(rng_state);
		value[31:16] = rng_state[31:16];
		rng_state = lcg_next(rng_state);
		value[15:0] = rng_state[31:16];
	endtask

	task report_mismatch(input string name, input logic [127:0] got, input logic [127:0] exp);
		$display("FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
		error_count++;
	endtask

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	// called on a falling edge with payload inputs already set
	task fire_triggers(input logic cmd, input logic irq);
		logic [255:0] pkt;
		if (cmd) begin
			pkt = expected_packet(rc_upd_cmd_mode, cmd_base_rc, cmd_response, cmd_error_code);
			exp_desc_q.push_back(pkt[255:128]);
			exp_data_q.push_back(pkt[127:0]);
			expected_count++;
		end
		if (irq) begin
			pkt = expected_packet(rc_upd_irq_mode, irq_base_rc, 64'h0, 64'h0);
			exp_desc_q.push_back(pkt[255:128]);
			exp_data_q.push_back(pkt[127:0]);
			expected_count++;
		end
		cmd_done = cmd;
		irq_strobe = irq;
		@(negedge clk_in);
		cmd_done = 1'b0;
		irq_strobe = 1'b0;
	endtask

	// watchdog covers a packet that never shows up
	task wait_packets_checked;
		wait (checked_count >= expected_count);
		@(negedge clk_in);
	endtask

	task check_port_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk_in);
			check_count++;
			assert (tx_req == 1'b0) else report_mismatch("tx_req", tx_req, 0);
			assert (tx_dfr == 1'b0) else report_mismatch("tx_dfr", tx_dfr, 0);
			assert (tx_dv == 1'b0) else report_mismatch("tx_dv", tx_dv, 0);
		end
	endtask

	task finish_test(input string name, input int errors_before);
		test_count++;
		$display("test %0d %s: %s", test_count, name,
			(error_count == errors_before) ? "ok" : "errors found");
	endtask

	// --------------------------------------------------
	// comparison against expected packets
	// --------------------------------------------------
	always @(negedge clk_in) begin : compare_captures
		logic [127:0] cap_desc;
		logic [127:0] cap_data;
		int idx;
		while (checked_count < capture_count) begin
			tx_sink_model_inst.pop_capture(cap_desc, cap_data);
			if (exp_desc_q.size() == 0) begin
				$display("error at %0t ns: beat captured with no trigger outstanding", $time);
				error_count++;
			end else begin
				// match by descriptor, either writer may go first
				idx = 0;
				for (int i = 0; i < exp_desc_q.size(); i++) begin
					if (exp_desc_q[i] == cap_desc)
						idx = i;
				end
				check_count += 2;
				assert (cap_desc == exp_desc_q[idx])
					else report_mismatch("tx_desc", cap_desc, exp_desc_q[idx]);
				assert (cap_data == exp_data_q[idx])
					else report_mismatch("tx_data", cap_data, exp_data_q[idx]);
				exp_desc_q.delete(idx);
				exp_data_q.delete(idx);
			end
			checked_count++;
		end
	end

	// framing and back-pressure rules on the port
	always @(posedge clk_in) begin
		if (!rst_in) begin
			if (tx_req && !req_q) begin
				assert (!pkt_open) else begin
					$display("error at %0t ns: tx_req rose before the last beat was taken", $time);
					error_count++;
				end
				// dfr is up from the first request cycle
				check_count++;
				assert (tx_dfr) else report_mismatch("tx_dfr", tx_dfr, 1);
				pkt_open = 1'b1;
			end
			if (tx_dv && !tx_ws)
				pkt_open = 1'b0;
			assert (!(ws_q && (dv_q != tx_dv))) else begin
				$display("error at %0t ns: tx_dv changed while tx_ws was high", $time);
				error_count++;
			end
			req_q = tx_req;
			ws_q = tx_ws;
			dv_q = tx_dv;
		end
	end

	initial begin : watchdog
		#(num_tests * cycles_per_test * clk_period);
		$display("error: watchdog expired, a packet did not complete in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin : main_sequence
		logic [31:0] r;
		logic [31:0] hi;
		logic [31:0] status;
		int errors_before;
		rst_in = 1'b0;
		init = 1'b0;
		cmd_done = 1'b0;
		irq_strobe = 1'b0;
		cmd_base_rc = '0;
		cmd_response = '0;
		cmd_error_code = '0;
		irq_base_rc = '0;
		sfp1_on = 1'b0;
		sfp2_on = 1'b0;
		byte_ready = '0;
		byte_sent = '0;
		rx_ring_wptr = '0;
		tx_ring_rptr = '0;
		rng_state = 32'd76034;
		#5 rst_in = 1'b1;
		repeat (reset_cycles) @(posedge clk_in);
		@(negedge clk_in);
		rst_in = 1'b0;

		errors_before = error_count;
		check_port_quiet(8);
		finish_test("port idle after reset", errors_before);

		// 64-bit base, 4dw header
		errors_before = error_count;
		cmd_base_rc = 64'h0000_0012_3456_7800;
		cmd_response = 64'h0123_4567_89ab_cdef;
		cmd_error_code = 64'h0000_0000_dead_0001;
		fire_triggers(1'b1, 1'b0);
		wait_packets_checked();
		finish_test("command write 4dw", errors_before);

		// 32-bit base, 3dw header, byte_ready zero then nonzero
		errors_before = error_count;
		irq_base_rc = 64'h0000_0000_fedc_ba00;
		sfp1_on = 1'b1;
		byte_sent = 32'h0000_1f40;
		rx_ring_wptr = 12'h3a5;
		tx_ring_rptr = 12'hc17;
		fire_triggers(1'b0, 1'b1);
		wait_packets_checked();
		sfp1_on = 1'b0;
		sfp2_on = 1'b1;
		byte_ready = 24'h00_0200;
		fire_triggers(1'b0, 1'b1);
		wait_packets_checked();
		finish_test("interrupt write 3dw", errors_before);

		// both strobes on one edge
		errors_before = error_count;
		cmd_base_rc = 64'h0000_0000_8000_1000;
		irq_base_rc = 64'h0000_0001_0000_2000;
		fire_triggers(1'b1, 1'b1);
		wait_packets_checked();
		finish_test("simultaneous writers", errors_before);

		// mixed random records under random wait states
		errors_before = error_count;
		repeat (random_packets) begin
			draw_random(r);
			draw_random(hi);
			// half the bases stay below 4 GB
			if (r[1])
				hi = 32'h0;
			if (r[0]) begin
				draw_random(cmd_base_rc[31:0]);
				cmd_base_rc[63:32] = hi;
				draw_random(cmd_response[63:32]);
				draw_random(cmd_response[31:0]);
				draw_random(cmd_error_code[31:0]);
				cmd_error_code[63:32] = r[31:0] ^ hi;
			end else begin
				draw_random(irq_base_rc[31:0]);
				irq_base_rc[63:32] = hi;
				draw_random(byte_sent);
				draw_random(status);
				byte_ready = status[2] ? 24'h0 : status[31:8];
				sfp1_on = status[3];
				sfp2_on = status[4];
				rx_ring_wptr = status[19:8];
				tx_ring_rptr = status[31:20];
			end
			fire_triggers(r[0], !r[0]);
			wait_packets_checked();
		end
		finish_test("random back-pressure", errors_before);

		// init pulse, then one packet still goes out
		errors_before = error_count;
		init = 1'b1;
		@(negedge clk_in);
		init = 1'b0;
		check_port_quiet(8);
		cmd_base_rc = 64'h0000_0000_0000_4440;
		fire_triggers(1'b1, 1'b0);
		wait_packets_checked();
		finish_test("port idle after init", errors_before);

		// one beat per trigger over the whole run
		check_count++;
		assert (capture_count == expected_count) else begin
			$display("error at %0t ns: %0d beats captured for %0d triggers",
				$time, capture_count, expected_count);
			error_count++;
		end

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+rtl
rtl/rc_update_pkg.sv
rtl/rc_update_sequencer.sv
rtl/rc_update_writer.sv
rtl/tx_port_arbiter.sv
rtl/rc_update_top.sv
test/tx_sink_model.sv
test/rc_update_tb.sv

// File: Bender.yml
package:
  name: rc_update

sources:
  - rtl/rc_update_pkg.sv
  - rtl/rc_update_sequencer.sv
  - rtl/rc_update_writer.sv
  - rtl/tx_port_arbiter.sv
  - rtl/rc_update_top.sv
  - target: test
    files:
      - test/tx_sink_model.sv
      - test/rc_update_tb.sv
